// File: filelist.f
source/DecodePkg.sv
source/MainDecoder.sv
source/AluControl.sv
source/ImmGen.sv
source/RegFile.sv
source/DecodeStage.sv
test/DecodeStage_assert.sv
test/DecodeStageTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module DecodeStageTb \
    -f filelist.f -Mdir obj_dir -o simv
if [ $? -ne 0 ]; then
    echo "compile step failed"
    exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -q "TEST PASSED"; then
    exit 0
fi
exit 1

// File: test/DecodeStageTb.sv
`timescale 1ns/100ps
`default_nettype none

module DecodeStageTb;

    localparam int maxRows = 48;

    logic                  clk = 1'b0;
    logic                  rst = 1'b1;
    logic                  instrValid = 1'b0;
    DecodePkg::word_t      instr = '0;
    DecodePkg::word_t      pc = '0;
    logic                  writeEnable = 1'b0;
    DecodePkg::regAddr_t   writeAddr = '0;
    DecodePkg::word_t      writeData = '0;
    logic                  decodeValid;
    DecodePkg::word_t      readDataA;
    DecodePkg::word_t      readDataB;
    DecodePkg::word_t      imm;
    DecodePkg::word_t      pcPlus4;
    DecodePkg::regAddr_t   rd;
    DecodePkg::regAddr_t   rs1;
    DecodePkg::regAddr_t   rs2;
    logic                  regWrite;
    logic                  memWrite;
    logic                  branch;
    logic                  jump;
    logic                  aluSrcA;
    logic                  aluSrcB;
    DecodePkg::aluCtrl_t   aluCtrl;
    DecodePkg::resultSel_t resultSel;

    // stimulus and expected values, one entry per cycle
    logic                  rowWe [maxRows];
    DecodePkg::regAddr_t   rowWa [maxRows];
    DecodePkg::word_t      rowWd [maxRows];
    logic                  rowValid [maxRows];
    DecodePkg::word_t      rowInstr [maxRows];
    DecodePkg::word_t      rowPc [maxRows];
    logic [5:0]            rowFlags [maxRows];
    DecodePkg::aluCtrl_t   rowCtrl [maxRows];
    DecodePkg::word_t      rowImm [maxRows];
    DecodePkg::resultSel_t rowSel [maxRows];
    DecodePkg::word_t      expA [maxRows];
    DecodePkg::word_t      expB [maxRows];
    DecodePkg::word_t      shadow [32];
    int                    rowCount = 0;
    int                    cycleCount = 0;
    int                    heldRow = -1;

    DecodeStage #(
        .regCount (32)
    ) DecodeStage_inst (
        .clk (clk), .rst (rst), .instrValid (instrValid), .instr (instr), .pc (pc),
        .writeEnable (writeEnable), .writeAddr (writeAddr), .writeData (writeData),
        .decodeValid (decodeValid), .readDataA (readDataA), .readDataB (readDataB),
        .imm (imm), .pcPlus4 (pcPlus4), .rd (rd), .rs1 (rs1), .rs2 (rs2),
        .regWrite (regWrite), .memWrite (memWrite), .branch (branch), .jump (jump),
        .aluSrcA (aluSrcA), .aluSrcB (aluSrcB), .aluCtrl (aluCtrl), .resultSel (resultSel)
    );

    initial begin
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount > rowCount + 20) begin
            $display("timeout: the stimulus table did not finish in time");
            $display("TEST FAILED");
            $fatal(1);
        end
    end

    // instruction encoders
    function automatic DecodePkg::word_t rType(input logic [6:0] funct7, input logic [4:0] src2,
        input logic [4:0] src1, input logic [2:0] funct3, input logic [4:0] dest);
        return {funct7, src2, src1, funct3, dest, DecodePkg::opR};
    endfunction

    function automatic DecodePkg::word_t iType(input logic [11:0] value, input logic [4:0] src1,
        input logic [2:0] funct3, input logic [4:0] dest, input logic [6:0] op);
        return {value, src1, funct3, dest, op};
    endfunction

    function automatic DecodePkg::word_t sType(input logic [11:0] value, input logic [4:0] src2,
        input logic [4:0] src1);
        return {value[11:5], src2, src1, 3'd2, value[4:0], DecodePkg::opStore};
    endfunction

    function automatic DecodePkg::word_t bType(input logic [12:0] value, input logic [4:0] src2,
        input logic [4:0] src1, input logic [2:0] funct3);
        return {value[12], value[10:5], src2, src1, funct3, value[4:1], value[11],
                DecodePkg::opBranch};
    endfunction

    function automatic DecodePkg::word_t jType(input logic [20:0] value, input logic [4:0] dest);
        return {value[20], value[10:1], value[11], value[19:12], dest, DecodePkg::opJal};
    endfunction

    task automatic addWrite(input logic enable, input DecodePkg::regAddr_t addr,
        input DecodePkg::word_t data);
        rowWe[rowCount] = enable;
        rowWa[rowCount] = addr;
        rowWd[rowCount] = data;
        rowValid[rowCount] = 1'b0;
        rowInstr[rowCount] = '0;
        rowPc[rowCount] = '0;
        rowFlags[rowCount] = '0;
        rowCtrl[rowCount] = DecodePkg::aluAdd;
        rowImm[rowCount] = '0;
        rowSel[rowCount] = DecodePkg::resultAlu;
        rowCount++;
    endtask

    task automatic addInstr(input DecodePkg::word_t word, input logic [5:0] flags,
        input DecodePkg::aluCtrl_t ctrl, input DecodePkg::word_t value,
        input DecodePkg::resultSel_t sel);
        addWrite(1'b0, 5'd0, 32'd0);
        rowValid[rowCount-1] = 1'b1;
        rowInstr[rowCount-1] = word;
        rowPc[rowCount-1] = $urandom & 32'hffff_fffc;
        rowFlags[rowCount-1] = flags;
        rowCtrl[rowCount-1] = ctrl;
        rowImm[rowCount-1] = value;
        rowSel[rowCount-1] = sel;
    endtask

    // same-edge write on the last row
    task automatic attachWrite(input DecodePkg::regAddr_t addr, input DecodePkg::word_t data);
        rowWe[rowCount-1] = 1'b1;
        rowWa[rowCount-1] = addr;
        rowWd[rowCount-1] = data;
    endtask

    task automatic addRType(input logic [6:0] funct7, input logic [2:0] funct3,
        input logic [4:0] src1, input logic [4:0] src2, input DecodePkg::aluCtrl_t ctrl);
        addInstr(rType(funct7, src2, src1, funct3, 5'd3), 6'b100000, ctrl, 32'd0,
                 DecodePkg::resultAlu);
    endtask

    task automatic addIType(input logic [11:0] value, input logic [2:0] funct3,
        input DecodePkg::aluCtrl_t ctrl, input DecodePkg::word_t expImm);
        addInstr(iType(value, 5'd1, funct3, 5'd8, DecodePkg::opImm), 6'b100001, ctrl, expImm,
                 DecodePkg::resultAlu);
    endtask

    task automatic buildTable();
        addWrite(1'b0, 5'd0, 32'd0);
        addRType(7'h00, 3'd0, 5'd1, 5'd2, DecodePkg::aluAdd);
        addWrite(1'b1, 5'd1, $urandom);
        addWrite(1'b1, 5'd2, $urandom);
        addWrite(1'b1, 5'd5, $urandom);
        addWrite(1'b1, 5'd6, $urandom);
        addRType(7'h00, 3'd0, 5'd1, 5'd2, DecodePkg::aluAdd);
        addRType(7'h20, 3'd0, 5'd2, 5'd1, DecodePkg::aluSub);
        addRType(7'h00, 3'd1, 5'd5, 5'd6, DecodePkg::aluSll);
        addRType(7'h00, 3'd2, 5'd6, 5'd5, DecodePkg::aluSlt);
        addRType(7'h00, 3'd3, 5'd1, 5'd6, DecodePkg::aluSltu);
        addRType(7'h00, 3'd4, 5'd2, 5'd5, DecodePkg::aluXor);
        addRType(7'h00, 3'd5, 5'd5, 5'd1, DecodePkg::aluSrl);
        addRType(7'h20, 3'd5, 5'd6, 5'd2, DecodePkg::aluSra);
        addRType(7'h00, 3'd6, 5'd1, 5'd5, DecodePkg::aluOr);
        addRType(7'h00, 3'd7, 5'd2, 5'd6, DecodePkg::aluAnd);
        addIType(12'hffb, 3'd0, DecodePkg::aluAdd, 32'hffff_fffb);
        addIType(12'h400, 3'd0, DecodePkg::aluAdd, 32'h0000_0400);
        addIType(12'h7ff, 3'd2, DecodePkg::aluSlt, 32'h0000_07ff);
        addIType(12'h800, 3'd4, DecodePkg::aluXor, 32'hffff_f800);
        addIType(12'h003, 3'd1, DecodePkg::aluSll, 32'h0000_0003);
        addIType(12'h004, 3'd5, DecodePkg::aluSrl, 32'h0000_0004);
        addIType(12'h404, 3'd5, DecodePkg::aluSra, 32'h0000_0404);
        addIType(12'h0f0, 3'd7, DecodePkg::aluAnd, 32'h0000_00f0);
        addInstr(iType(12'h010, 5'd2, 3'd2, 5'd9, DecodePkg::opLoad), 6'b100001,
                 DecodePkg::aluAdd, 32'h0000_0010, DecodePkg::resultMem);
        addInstr(sType(12'hff8, 5'd5, 5'd1), 6'b010001,
                 DecodePkg::aluAdd, 32'hffff_fff8, DecodePkg::resultAlu);
        addInstr(bType(13'h1ff0, 5'd2, 5'd1, 3'd0), 6'b001000,
                 DecodePkg::aluSub, 32'hffff_fff0, DecodePkg::resultAlu);
        addInstr(bType(13'h0800, 5'd6, 5'd5, 3'd1), 6'b001000,
                 DecodePkg::aluSub, 32'h0000_0800, DecodePkg::resultAlu);
        addInstr(jType(21'h012344, 5'd1), 6'b100111,
                 DecodePkg::aluAdd, 32'h0001_2344, DecodePkg::resultPc);
        addInstr(jType(21'h1ffffc, 5'd1), 6'b100111,
                 DecodePkg::aluAdd, 32'hffff_fffc, DecodePkg::resultPc);
        addInstr(iType(12'h00c, 5'd5, 3'd0, 5'd1, DecodePkg::opJalr), 6'b100101,
                 DecodePkg::aluAdd, 32'h0000_000c, DecodePkg::resultPc);
        addInstr({20'habcde, 5'd10, DecodePkg::opLui}, 6'b100001,
                 DecodePkg::aluAdd, 32'habcd_e000, DecodePkg::resultAlu);
        addInstr({20'h00012, 5'd11, DecodePkg::opAuipc}, 6'b100011,
                 DecodePkg::aluAdd, 32'h0001_2000, DecodePkg::resultAlu);
        // x0 stays zero, then bypass cases
        addWrite(1'b1, 5'd0, $urandom);
        addRType(7'h00, 3'd0, 5'd0, 5'd1, DecodePkg::aluAdd);
        addRType(7'h00, 3'd0, 5'd12, 5'd12, DecodePkg::aluAdd);
        attachWrite(5'd12, $urandom);
        addRType(7'h20, 3'd0, 5'd1, 5'd2, DecodePkg::aluSub);
        attachWrite(5'd1, $urandom);
        addRType(7'h00, 3'd0, 5'd1, 5'd0, DecodePkg::aluAdd);
        attachWrite(5'd0, $urandom);
        addInstr(32'hffff_ffff, 6'b000000, DecodePkg::aluAdd, 32'd0, DecodePkg::resultAlu);
        addInstr(32'h1234_500b, 6'b000000, DecodePkg::aluAdd, 32'd0, DecodePkg::resultAlu);
        addWrite(1'b0, 5'd0, 32'd0);
    endtask

    function automatic DecodePkg::word_t expectedRead(input DecodePkg::regAddr_t addr,
        input int i);
        if (addr == 5'd0) begin
            return 32'd0;
        end
        if (rowWe[i] && rowWa[i] == addr) begin
            return rowWd[i];
        end
        return shadow[addr];
    endfunction

    task automatic checkValue(input string name, input logic [31:0] expected,
        input logic [31:0] actual);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s expected %h, actual %h", $time, name, expected, actual);
            $display("TEST FAILED");
            $fatal(1);
        end
    endtask

    task automatic applyRow(input int i);
        expA[i] = expectedRead(rowInstr[i][19:15], i);
        expB[i] = expectedRead(rowInstr[i][24:20], i);
        if (rowWe[i] && rowWa[i] != 5'd0) begin
            shadow[rowWa[i]] = rowWd[i];
        end
        instrValid  <= rowValid[i];
        instr       <= rowInstr[i];
        pc          <= rowPc[i];
        writeEnable <= rowWe[i];
        writeAddr   <= rowWa[i];
        writeData   <= rowWd[i];
    endtask

    task automatic checkRow(input int j);
        logic [5:0] expFlags;
        checkValue("decodeValid", 32'(rowValid[j]), 32'(decodeValid));
        if (rowValid[j]) begin
            heldRow = j;
        end
        if (heldRow >= 0) begin
            // enables last one cycle, the rest of the bundle holds
            expFlags = rowValid[j] ? rowFlags[heldRow] : {4'b0000, rowFlags[heldRow][1:0]};
            checkValue("readDataA", expA[heldRow], readDataA);
            checkValue("readDataB", expB[heldRow], readDataB);
            checkValue("imm", rowImm[heldRow], imm);
            checkValue("pcPlus4", rowPc[heldRow] + 32'd4, pcPlus4);
            checkValue("rd", 32'(rowInstr[heldRow][11:7]), 32'(rd));
            checkValue("rs1", 32'(rowInstr[heldRow][19:15]), 32'(rs1));
            checkValue("rs2", 32'(rowInstr[heldRow][24:20]), 32'(rs2));
            checkValue("{regWrite,memWrite,branch,jump,aluSrcA,aluSrcB}", 32'(expFlags),
                       32'({regWrite, memWrite, branch, jump, aluSrcA, aluSrcB}));
            checkValue("aluCtrl", 32'(rowCtrl[heldRow]), 32'(aluCtrl));
            checkValue("resultSel", 32'(rowSel[heldRow]), 32'(resultSel));
        end else begin
            checkValue("regWrite", 32'd0, 32'(regWrite));
            checkValue("memWrite", 32'd0, 32'(memWrite));
            checkValue("branch", 32'd0, 32'(branch));
            checkValue("jump", 32'd0, 32'(jump));
        end
    endtask

    initial begin
        void'($urandom(32'hcbde));
        for (int r = 0; r < 32; r++) begin
            shadow[r] = 32'd0;
        end
        buildTable();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        checkValue("decodeValid", 32'd0, 32'(decodeValid));
        // each row is checked one cycle after it is driven
        for (int i = 0; i <= rowCount; i++) begin
            @(posedge clk);
            if (i < rowCount) begin
                applyRow(i);
            end else begin
                instrValid  <= 1'b0;
                writeEnable <= 1'b0;
            end
            @(negedge clk);
            if (i > 0) begin
                checkRow(i - 1);
            end
        end
        $display("TEST PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: test/DecodeStage_assert.sv
`timescale 1ns/100ps
`default_nettype none

module DecodeStageAssert (
    input wire                      clk,
    input wire                      rst,
    input wire                      instrValid,
    input wire                      decodeValid,
    input wire                      regWrite,
    input wire                      memWrite,
    input wire                      branch,
    input wire DecodePkg::regAddr_t rs1,
    input wire DecodePkg::word_t    readDataA
);

    // one cycle from strobe to valid output
    validLatency: assert property (@(posedge clk) disable iff (rst)
        !rst |=> (decodeValid == $past(instrValid)))
        else $error("decodeValid does not follow instrValid by one cycle");

    writeExclusive: assert property (@(posedge clk) disable iff (rst)
        !(regWrite && memWrite))
        else $error("regWrite and memWrite are high together");

    branchNoWrite: assert property (@(posedge clk) disable iff (rst)
        branch |-> !regWrite)
        else $error("branch is high together with regWrite");

    zeroRegister: assert property (@(posedge clk) disable iff (rst)
        (decodeValid && rs1 == 5'd0) |-> (readDataA == 32'd0))
        else $error("x0 read returned nonzero data");

endmodule

bind DecodeStage DecodeStageAssert DecodeStageAssert_inst (
    .clk         (clk),
    .rst         (rst),
    .instrValid  (instrValid),
    .decodeValid (decodeValid),
    .regWrite    (regWrite),
    .memWrite    (memWrite),
    .branch      (branch),
    .rs1         (rs1),
    .readDataA   (readDataA)
);

`default_nettype wire

// File: source/DecodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module DecodeStage #(
    parameter int regCount = 32
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire                      instrValid,
    input  wire DecodePkg::word_t    instr,
    input  wire DecodePkg::word_t    pc,
    input  wire                      writeEnable,
    input  wire DecodePkg::regAddr_t writeAddr,
    input  wire DecodePkg::word_t    writeData,
    output logic                     decodeValid,
    output DecodePkg::word_t         readDataA,
    output DecodePkg::word_t         readDataB,
    output DecodePkg::word_t         imm,
    output DecodePkg::word_t         pcPlus4,
    output DecodePkg::regAddr_t      rd,
    output DecodePkg::regAddr_t      rs1,
    output DecodePkg::regAddr_t      rs2,
    output logic                     regWrite,
    output logic                     memWrite,
    output logic                     branch,
    output logic                     jump,
    output logic                     aluSrcA,
    output logic                     aluSrcB,
    output DecodePkg::aluCtrl_t      aluCtrl,
    output DecodePkg::resultSel_t    resultSel
);

    DecodePkg::opcode_t    opcode;
    DecodePkg::regAddr_t   rdField;
    DecodePkg::regAddr_t   rs1Field;
    DecodePkg::regAddr_t   rs2Field;
    DecodePkg::word_t      pcNext;
    DecodePkg::aluOp_t     aluOp;
    DecodePkg::immSrc_t    immSrc;
    DecodePkg::aluCtrl_t   decAluCtrl;
    DecodePkg::resultSel_t decResultSel;
    DecodePkg::word_t      decImm;
    DecodePkg::word_t      regDataA;
    DecodePkg::word_t      regDataB;
    logic                  decRegWrite;
    logic                  decMemWrite;
    logic                  decBranch;
    logic                  decJump;
    logic                  decAluSrcA;
    logic                  decAluSrcB;

    assign opcode   = instr[6:0];
    assign rdField  = instr[11:7];
    assign rs1Field = instr[19:15];
    assign rs2Field = instr[24:20];
    assign pcNext   = pc + 32'd4;

    MainDecoder MainDecoder_inst (
        .opcode    (opcode),
        .regWrite  (decRegWrite),
        .memWrite  (decMemWrite),
        .branch    (decBranch),
        .jump      (decJump),
        .aluSrcA   (decAluSrcA),
        .aluSrcB   (decAluSrcB),
        .aluOp     (aluOp),
        .immSrc    (immSrc),
        .resultSel (decResultSel)
    );

    AluControl AluControl_inst (
        .aluOp    (aluOp),
        .funct3   (instr[14:12]),
        .funct7b5 (instr[30]),
        .aluCtrl  (decAluCtrl)
    );

    ImmGen ImmGen_inst (
        .instrBits (instr[31:7]),
        .immSrc    (immSrc),
        .imm       (decImm)
    );

    RegFile #(
        .regCount (regCount)
    ) RegFile_inst (
        .clk         (clk),
        .rst         (rst),
        .readAddrA   (rs1Field),
        .readAddrB   (rs2Field),
        .readDataA   (regDataA),
        .readDataB   (regDataB),
        .writeEnable (writeEnable),
        .writeAddr   (writeAddr),
        .writeData   (writeData)
    );

    // strobe and enables drop when nothing valid comes in
    always_ff @(posedge clk) begin
        if (rst) begin
            decodeValid <= 1'b0;
            regWrite    <= 1'b0;
            memWrite    <= 1'b0;
            branch      <= 1'b0;
            jump        <= 1'b0;
        end else begin
            decodeValid <= instrValid;
            regWrite    <= instrValid && decRegWrite;
            memWrite    <= instrValid && decMemWrite;
            branch      <= instrValid && decBranch;
            jump        <= instrValid && decJump;
        end
    end

    // rest of the bundle held until the next valid instruction
    always_ff @(posedge clk) begin
        if (instrValid) begin
            readDataA <= regDataA;
            readDataB <= regDataB;
            imm       <= decImm;
            pcPlus4   <= pcNext;
            rd        <= rdField;
            rs1       <= rs1Field;
            rs2       <= rs2Field;
            aluSrcA   <= decAluSrcA;
            aluSrcB   <= decAluSrcB;
            aluCtrl   <= decAluCtrl;
            resultSel <= decResultSel;
        end
    end

endmodule

`default_nettype wire

// File: source/RegFile.sv
`timescale 1ns/100ps
`default_nettype none

module RegFile #(
    parameter int regCount = 32
) (
    input  wire                      clk,
    input  wire                      rst,
    input  wire DecodePkg::regAddr_t readAddrA,
    input  wire DecodePkg::regAddr_t readAddrB,
    output DecodePkg::word_t         readDataA,
    output DecodePkg::word_t         readDataB,
    input  wire                      writeEnable,
    input  wire DecodePkg::regAddr_t writeAddr,
    input  wire DecodePkg::word_t    writeData
);

    localparam int indexWidth = $clog2(regCount);

    logic [indexWidth-1:0] indexA;
    logic [indexWidth-1:0] indexB;
    logic [indexWidth-1:0] indexW;
    DecodePkg::word_t      regs [regCount];

    // rv32e keeps only the low index bits
    assign indexA = readAddrA[indexWidth-1:0];
    assign indexB = readAddrB[indexWidth-1:0];
    assign indexW = writeAddr[indexWidth-1:0];

    // x0 first, then same-cycle write bypass
    assign readDataA = (indexA == '0) ? '0 :
                       (writeEnable && indexW == indexA) ? writeData : regs[indexA];
    assign readDataB = (indexB == '0) ? '0 :
                       (writeEnable && indexW == indexB) ? writeData : regs[indexB];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEnable && indexW != '0) begin
            regs[indexW] <= writeData;
        end
    end

endmodule

`default_nettype wire

// File: source/ImmGen.sv
`timescale 1ns/100ps
`default_nettype none

module ImmGen (
    input  wire [31:7]              instrBits,
    input  wire DecodePkg::immSrc_t immSrc,
    output DecodePkg::word_t        imm
);

    logic signBit;

    assign signBit = instrBits[31];

    always_comb begin
        case (immSrc)
            DecodePkg::immI: begin
                imm = {{20{signBit}}, instrBits[31:20]};
            end
            DecodePkg::immS: begin
                imm = {{20{signBit}}, instrBits[31:25], instrBits[11:7]};
            end
            DecodePkg::immB: begin
                imm = {{20{signBit}}, instrBits[7], instrBits[30:25],
                       instrBits[11:8], 1'b0};
            end
            DecodePkg::immJ: begin
                imm = {{12{signBit}}, instrBits[19:12], instrBits[20],
                       instrBits[30:21], 1'b0};
            end
            // upper immediate, low bits zero
            DecodePkg::immU: begin
                imm = {instrBits[31:12], 12'b0};
            end
            default: begin
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/AluControl.sv
`timescale 1ns/100ps
`default_nettype none

module AluControl (
    input  wire DecodePkg::aluOp_t aluOp,
    input  wire [2:0]              funct3,
    input  wire                    funct7b5,
    output DecodePkg::aluCtrl_t    aluCtrl
);

    logic subSelect;

    // only register-register ops use bit 30 to pick sub
    assign subSelect = (aluOp == DecodePkg::aluOpFunct) && funct7b5;

    always_comb begin
        case (aluOp)
            DecodePkg::aluOpAdd: aluCtrl = DecodePkg::aluAdd;
            DecodePkg::aluOpSub: aluCtrl = DecodePkg::aluSub;
            default: begin
                // funct and immediate classes share the funct3 map
                case (funct3)
                    3'b000:  aluCtrl = subSelect ? DecodePkg::aluSub : DecodePkg::aluAdd;
                    3'b001:  aluCtrl = DecodePkg::aluSll;
                    3'b010:  aluCtrl = DecodePkg::aluSlt;
                    3'b011:  aluCtrl = DecodePkg::aluSltu;
                    3'b100:  aluCtrl = DecodePkg::aluXor;
                    3'b101:  aluCtrl = funct7b5 ? DecodePkg::aluSra : DecodePkg::aluSrl;
                    3'b110:  aluCtrl = DecodePkg::aluOr;
                    default: aluCtrl = DecodePkg::aluAnd;
                endcase
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/MainDecoder.sv
`timescale 1ns/100ps
`default_nettype none

module MainDecoder (
    input  wire DecodePkg::opcode_t opcode,
    output logic                    regWrite,
    output logic                    memWrite,
    output logic                    branch,
    output logic                    jump,
    output logic                    aluSrcA,
    output logic                    aluSrcB,
    output DecodePkg::aluOp_t       aluOp,
    output DecodePkg::immSrc_t      immSrc,
    output DecodePkg::resultSel_t   resultSel
);

    always_comb begin
        // inert defaults, also what an unknown opcode gets
        regWrite  = 1'b0;
        memWrite  = 1'b0;
        branch    = 1'b0;
        jump      = 1'b0;
        aluSrcA   = 1'b0;
        aluSrcB   = 1'b0;
        aluOp     = DecodePkg::aluOpAdd;
        immSrc    = DecodePkg::immNone;
        resultSel = DecodePkg::resultAlu;

        case (opcode)
            DecodePkg::opR: begin
                regWrite = 1'b1;
                aluOp    = DecodePkg::aluOpFunct;
            end
            DecodePkg::opImm: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                aluOp    = DecodePkg::aluOpImm;
                immSrc   = DecodePkg::immI;
            end
            DecodePkg::opLoad: begin
                regWrite  = 1'b1;
                aluSrcB   = 1'b1;
                immSrc    = DecodePkg::immI;
                resultSel = DecodePkg::resultMem;
            end
            DecodePkg::opStore: begin
                memWrite = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = DecodePkg::immS;
            end
            DecodePkg::opBranch: begin
                // compare by subtraction
                branch = 1'b1;
                aluOp  = DecodePkg::aluOpSub;
                immSrc = DecodePkg::immB;
            end
            DecodePkg::opJal: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                aluSrcA   = 1'b1;
                aluSrcB   = 1'b1;
                immSrc    = DecodePkg::immJ;
                resultSel = DecodePkg::resultPc;
            end
            DecodePkg::opJalr: begin
                regWrite  = 1'b1;
                jump      = 1'b1;
                aluSrcB   = 1'b1;
                immSrc    = DecodePkg::immI;
                resultSel = DecodePkg::resultPc;
            end
            DecodePkg::opLui: begin
                regWrite = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = DecodePkg::immU;
            end
            DecodePkg::opAuipc: begin
                regWrite = 1'b1;
                aluSrcA  = 1'b1;
                aluSrcB  = 1'b1;
                immSrc   = DecodePkg::immU;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/DecodePkg.sv
`default_nettype none

package DecodePkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  regAddr_t;
    typedef logic [6:0]  opcode_t;
    typedef logic [1:0]  aluOp_t;
    typedef logic [3:0]  aluCtrl_t;
    typedef logic [2:0]  immSrc_t;
    typedef logic [1:0]  resultSel_t;

    // RV32I base opcodes
    localparam opcode_t opR      = 7'b0110011;
    localparam opcode_t opImm    = 7'b0010011;
    localparam opcode_t opLoad   = 7'b0000011;
    localparam opcode_t opStore  = 7'b0100011;
    localparam opcode_t opBranch = 7'b1100011;
    localparam opcode_t opJal    = 7'b1101111;
    localparam opcode_t opJalr   = 7'b1100111;
    localparam opcode_t opLui    = 7'b0110111;
    localparam opcode_t opAuipc  = 7'b0010111;

    // operation class handed from the main decoder to the ALU decoder
    localparam aluOp_t aluOpAdd   = 2'd0;
    localparam aluOp_t aluOpSub   = 2'd1;
    localparam aluOp_t aluOpFunct = 2'd2;
    localparam aluOp_t aluOpImm   = 2'd3;

    localparam aluCtrl_t aluAdd  = 4'h0;
    localparam aluCtrl_t aluSub  = 4'h1;
    localparam aluCtrl_t aluSll  = 4'h2;
    localparam aluCtrl_t aluSlt  = 4'h3;
    localparam aluCtrl_t aluSltu = 4'h4;
    localparam aluCtrl_t aluXor  = 4'h5;
    localparam aluCtrl_t aluSrl  = 4'h6;
    localparam aluCtrl_t aluSra  = 4'h7;
    localparam aluCtrl_t aluOr   = 4'h8;
    localparam aluCtrl_t aluAnd  = 4'h9;

    localparam immSrc_t immNone = 3'd0;
    localparam immSrc_t immI    = 3'd1;
    localparam immSrc_t immS    = 3'd2;
    localparam immSrc_t immB    = 3'd3;
    localparam immSrc_t immJ    = 3'd4;
    localparam immSrc_t immU    = 3'd5;

    localparam resultSel_t resultAlu = 2'd0;
    localparam resultSel_t resultMem = 2'd1;
    localparam resultSel_t resultPc  = 2'd2;

endpackage

`default_nettype wire
